// ==== include/memtest_consts.svh ====
//**************************************************************************
// global sizes for the memory exerciser, included by the package and by
// every module that needs a width, a depth or the channel count
//**************************************************************************
`ifndef MEMTEST_CONSTS_SVH
`define MEMTEST_CONSTS_SVH

// channel select, the high bits of the host address
`define MT_NUM_CHANNELS 4
`define MT_CHAN_W       2
// word address and data inside one channel
`define MT_MEM_ADDR_W   8
`define MT_DATA_W       64
`define MT_TAG_W        4
// queue depths, equal to the initial credit counts
`define MT_CMD_DEPTH    4
`define MT_RSP_DEPTH    2
// self-test window from word 0, and model read latency
`define MT_TEST_WORDS   64
`define MT_RD_LATENCY   2

`endif

// ==== src/memtest_pkg.sv ====
//**************************************************************************
// types shared by the exerciser: host commands, host results and the
// avalon-style request bundle from a channel engine to its memory
//**************************************************************************
`include "memtest_consts.svh"

package memtest_pkg;

   // operations a channel engine can run
   typedef enum logic [1:0] {
      MT_OP_WRITE,
      MT_OP_READ,
      MT_OP_ADDR_TEST
   } mem_op_t;

   // host command, channel select sits in the top addr bits
   typedef struct packed {
      mem_op_t                                op;
      logic [`MT_TAG_W-1:0]                   tag;
      logic [`MT_CHAN_W+`MT_MEM_ADDR_W-1:0]   addr;
      logic [`MT_DATA_W-1:0]                  wdata;
   } mem_cmd_t;

   // one result per command
   typedef struct packed {
      mem_op_t                                op;
      logic [`MT_TAG_W-1:0]                   tag;
      logic [`MT_CHAN_W-1:0]                  chan;
      logic [`MT_DATA_W-1:0]                  rdata;
      // self-test mismatches, wide enough for a full window
      logic [`MT_MEM_ADDR_W:0]                err_count;
   } mem_rsp_t;

   // master request side of the memory port
   typedef struct packed {
      logic [`MT_MEM_ADDR_W-1:0]              address;
      logic                                   write;
      logic                                   read;
      logic [`MT_DATA_W-1:0]                  writedata;
   } mem_port_t;

endpackage

// ==== src/credit_fifo.sv ====
//**************************************************************************
// register-array fifo for any payload type; each pop sends a one-cycle
// credit pulse back to the producer, which never pushes without credit
//**************************************************************************
`timescale 1ns/1ps

module credit_fifo #(
   parameter type ITEM_T = logic,
   parameter int  DEPTH  = 4
) (
   input  logic  pClk,
   input  logic  rst_n,
   input  logic  push,
   input  ITEM_T item_in,
   input  logic  pop,
   output ITEM_T item_out,
   output logic  not_empty,
   output logic  credit
);
   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   ITEM_T         mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          do_pop;

   // a pop on an empty queue is dropped
   assign do_pop    = pop & not_empty;
   assign not_empty = (count != '0);
   // head of queue is always visible
   assign item_out  = mem[rd_ptr];

   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count  <= count + CW'(push) - CW'(do_pop);
         // credit lands one cycle after the pop
         credit <= do_pop;
      end
   end

   always_ff @(posedge pClk) begin
      if (push) begin
         mem[wr_ptr] <= item_in;
      end
   end

endmodule

// ==== src/mem_cmd_dispatch.sv ====
//**************************************************************************
// host command ingress: picks the channel from the high address bits,
// tracks command-queue credits per channel and registers the push
//**************************************************************************
`timescale 1ns/1ps
`include "memtest_consts.svh"

module mem_cmd_dispatch (
   input  logic                  pClk,
   input  logic                  rst_n,
   input  memtest_pkg::mem_cmd_t host_cmd,
   input  logic                  host_cmd_valid,
   input  logic                  cmd_credit [`MT_NUM_CHANNELS],
   output logic                  host_cmd_ready,
   output memtest_pkg::mem_cmd_t chan_cmd,
   output logic                  chan_cmd_push [`MT_NUM_CHANNELS]
);
   localparam int N   = `MT_NUM_CHANNELS;
   localparam int CW  = `MT_CHAN_W;
   localparam int AW  = `MT_MEM_ADDR_W;
   localparam int CRW = $clog2(`MT_CMD_DEPTH + 1);

   logic [CW-1:0]  sel;
   logic           accept;
   logic           take [N];
   logic [CRW-1:0] credits [N];

   // channel select is the top of the host address
   assign sel            = host_cmd.addr[CW+AW-1:AW];
   // ready only while the target queue has room
   assign host_cmd_ready = (credits[sel] != '0);
   assign accept         = host_cmd_valid & host_cmd_ready;

   always_comb begin
      for (int i = 0; i < N; i++) begin
         take[i] = accept & (sel == CW'(i));
      end
   end

   //************************************************************************
   // credit counters and push strobes
   //************************************************************************
   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         for (int i = 0; i < N; i++) begin
            // queues start empty, so full credit
            credits[i]       <= CRW'(`MT_CMD_DEPTH);
            chan_cmd_push[i] <= 1'b0;
         end
      end else begin
         for (int i = 0; i < N; i++) begin
            // spend on accept, refund on the queue's pop pulse
            credits[i]       <= credits[i] - CRW'(take[i]) + CRW'(cmd_credit[i]);
            chan_cmd_push[i] <= take[i];
         end
      end
   end

   // shared command bus, only the push bit is per channel
   always_ff @(posedge pClk) begin
      if (accept) begin
         chan_cmd <= host_cmd;
      end
   end

endmodule

// ==== src/mem_chan_fsm.sv ====
//**************************************************************************
// one channel engine: queues host commands and runs posted write,
// non-posted read or the address self-test on its avalon-style master
//**************************************************************************
`timescale 1ns/1ps
`include "memtest_consts.svh"

module mem_chan_fsm #(
   parameter int CHAN_ID = 0
) (
   input  logic                   pClk,
   input  logic                   rst_n,
   input  memtest_pkg::mem_cmd_t  chan_cmd,
   input  logic                   chan_cmd_push,
   input  logic                   rsp_credit,
   input  logic                   waitrequest,
   input  logic [`MT_DATA_W-1:0]  readdata,
   input  logic                   readdatavalid,
   output logic                   cmd_credit,
   output memtest_pkg::mem_port_t mem_req,
   output memtest_pkg::mem_rsp_t  rsp,
   output logic                   rsp_push
);
   import memtest_pkg::*;

   localparam int AW = `MT_MEM_ADDR_W;
   localparam int DW = `MT_DATA_W;
   localparam int CW = `MT_CHAN_W;
   localparam int RW = $clog2(`MT_RSP_DEPTH + 1);
   localparam logic [AW-1:0] LAST_WORD = AW'(`MT_TEST_WORDS - 1);

   typedef enum logic [2:0] {
      IDLE,
      WR_REQ,
      RD_REQ,
      RD_RSP,
      TEST_WRITE,
      TEST_READ,
      DONE
   } state_t;

   state_t        state;
   mem_cmd_t      cur_cmd;
   logic          cmd_avail;
   logic          start;
   logic          req_taken;
   logic          mismatch;
   logic [RW-1:0] rsp_cred;
   logic [AW-1:0] chk_addr;
   logic [AW:0]   err_cnt;

   credit_fifo #(
      .ITEM_T (mem_cmd_t),
      .DEPTH  (`MT_CMD_DEPTH)
   ) cmd_q_i (
      .pClk      (pClk),
      .rst_n     (rst_n),
      .push      (chan_cmd_push),
      .item_in   (chan_cmd),
      .pop       (start),
      .item_out  (cur_cmd),
      .not_empty (cmd_avail),
      .credit    (cmd_credit)
   );

   // start only with a result slot reserved downstream
   assign start     = (state == IDLE) & cmd_avail & (rsp_cred != '0);
   // slave took the request this cycle
   assign req_taken = (mem_req.read | mem_req.write) & ~waitrequest;
   // self-test expects every word to hold its own address
   assign mismatch  = (readdata != DW'(chk_addr));
   assign rsp_push  = (state == DONE);

   //************************************************************************
   // main state machine
   //************************************************************************
   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         state           <= IDLE;
         mem_req.read    <= 1'b0;
         mem_req.write   <= 1'b0;
         mem_req.address <= '0;
         chk_addr        <= '0;
         err_cnt         <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  rsp.op        <= cur_cmd.op;
                  rsp.tag       <= cur_cmd.tag;
                  rsp.chan      <= CW'(CHAN_ID);
                  rsp.rdata     <= '0;
                  rsp.err_count <= '0;
                  chk_addr      <= '0;
                  err_cnt       <= '0;
                  case (cur_cmd.op)
                     MT_OP_WRITE: begin
                        mem_req.address   <= cur_cmd.addr[AW-1:0];
                        mem_req.writedata <= cur_cmd.wdata;
                        mem_req.write     <= 1'b1;
                        state             <= WR_REQ;
                     end
                     MT_OP_READ: begin
                        mem_req.address <= cur_cmd.addr[AW-1:0];
                        mem_req.read    <= 1'b1;
                        state           <= RD_REQ;
                     end
                     default: begin
                        // self-test starts writing at word 0
                        mem_req.address   <= '0;
                        mem_req.writedata <= '0;
                        mem_req.write     <= 1'b1;
                        state             <= TEST_WRITE;
                     end
                  endcase
               end
            end
            // posted write, done once accepted
            WR_REQ: begin
               if (req_taken) begin
                  mem_req.write <= 1'b0;
                  state         <= DONE;
               end
            end
            RD_REQ: begin
               if (req_taken) begin
                  mem_req.read <= 1'b0;
                  state        <= RD_RSP;
               end
            end
            RD_RSP: begin
               if (readdatavalid) begin
                  rsp.rdata <= readdata;
                  state     <= DONE;
               end
            end
            TEST_WRITE: begin
               if (req_taken) begin
                  if (mem_req.address == LAST_WORD) begin
                     // window written, turn around to readback
                     mem_req.write   <= 1'b0;
                     mem_req.read    <= 1'b1;
                     mem_req.address <= '0;
                     state           <= TEST_READ;
                  end else begin
                     mem_req.address   <= mem_req.address + 1'b1;
                     mem_req.writedata <= DW'(mem_req.address + 1'b1);
                  end
               end
            end
            TEST_READ: begin
               // issue side runs ahead of the returning data
               if (req_taken) begin
                  if (mem_req.address == LAST_WORD) begin
                     mem_req.read <= 1'b0;
                  end else begin
                     mem_req.address <= mem_req.address + 1'b1;
                  end
               end
               // check side, one word per readdatavalid, in order
               if (readdatavalid) begin
                  chk_addr <= chk_addr + 1'b1;
                  err_cnt  <= err_cnt + {{AW{1'b0}}, mismatch};
                  if (chk_addr == LAST_WORD) begin
                     rsp.err_count <= err_cnt + {{AW{1'b0}}, mismatch};
                     state         <= DONE;
                  end
               end
            end
            // result pushed while here
            DONE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // result credits, spent at start, returned when the collector pops
   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         rsp_cred <= RW'(`MT_RSP_DEPTH);
      end else begin
         rsp_cred <= rsp_cred - RW'(start) + RW'(rsp_credit);
      end
   end

endmodule

// ==== src/mem_model.sv ====
//**************************************************************************
// on-chip memory behind one channel, avalon-style slave with a one-cycle
// stall after every accepted request and a fixed read latency
//**************************************************************************
`timescale 1ns/1ps
`include "memtest_consts.svh"

module mem_model (
   input  logic                   pClk,
   input  logic                   rst_n,
   input  memtest_pkg::mem_port_t mem_req,
   output logic                   waitrequest,
   output logic [`MT_DATA_W-1:0]  readdata,
   output logic                   readdatavalid
);
   localparam int DW    = `MT_DATA_W;
   localparam int LAT   = `MT_RD_LATENCY;
   localparam int WORDS = 1 << `MT_MEM_ADDR_W;

   logic [DW-1:0]  mem [WORDS];
   logic [DW-1:0]  rd_pipe [LAT];
   logic [LAT-1:0] vld_pipe;
   logic           wr_accept;
   logic           rd_accept;

   // accepted only when not stalled
   assign wr_accept     = mem_req.write & ~waitrequest;
   assign rd_accept     = mem_req.read & ~waitrequest;
   assign readdata      = rd_pipe[LAT-1];
   assign readdatavalid = vld_pipe[LAT-1];

   // turnaround stall and read valid shift
   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         waitrequest <= 1'b0;
         vld_pipe    <= '0;
      end else begin
         waitrequest <= wr_accept | rd_accept;
         vld_pipe[0] <= rd_accept;
         for (int s = 1; s < LAT; s++) begin
            vld_pipe[s] <= vld_pipe[s-1];
         end
      end
   end

   // array and read data pipe, reads overlap freely
   always_ff @(posedge pClk) begin
      if (wr_accept) begin
         mem[mem_req.address] <= mem_req.writedata;
      end
      rd_pipe[0] <= mem[mem_req.address];
      for (int s = 1; s < LAT; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

endmodule

// ==== src/mem_rsp_collect.sv ====
//**************************************************************************
// result egress: one queue per channel, round-robin drain into the host
// output register, each pop returns a result credit to its channel
//**************************************************************************
`timescale 1ns/1ps
`include "memtest_consts.svh"

module mem_rsp_collect (
   input  logic                  pClk,
   input  logic                  rst_n,
   input  memtest_pkg::mem_rsp_t rsp [`MT_NUM_CHANNELS],
   input  logic                  rsp_push [`MT_NUM_CHANNELS],
   input  logic                  host_rsp_ready,
   output logic                  rsp_credit [`MT_NUM_CHANNELS],
   output memtest_pkg::mem_rsp_t host_rsp,
   output logic                  host_rsp_valid
);
   import memtest_pkg::*;

   localparam int N  = `MT_NUM_CHANNELS;
   localparam int CW = `MT_CHAN_W;

   mem_rsp_t      q_item [N];
   logic          q_ne [N];
   logic          pop [N];
   logic [CW-1:0] rr_ptr;
   logic [CW-1:0] sel;
   logic          sel_valid;
   logic          load;

   for (genvar g = 0; g < N; g++) begin : g_q
      credit_fifo #(
         .ITEM_T (mem_rsp_t),
         .DEPTH  (`MT_RSP_DEPTH)
      ) rsp_q_i (
         .pClk      (pClk),
         .rst_n     (rst_n),
         .push      (rsp_push[g]),
         .item_in   (rsp[g]),
         .pop       (pop[g]),
         .item_out  (q_item[g]),
         .not_empty (q_ne[g]),
         .credit    (rsp_credit[g])
      );
   end

   // output register free or being taken
   assign load = ~host_rsp_valid | host_rsp_ready;

   //************************************************************************
   // round-robin pick, nearest non-empty queue from rr_ptr wins
   //************************************************************************
   always_comb begin
      logic [CW-1:0] idx;
      sel       = rr_ptr;
      sel_valid = 1'b0;
      // walk backwards so the closest candidate is written last
      for (int k = N - 1; k >= 0; k--) begin
         idx = rr_ptr + CW'(k);
         if (q_ne[idx]) begin
            sel       = idx;
            sel_valid = 1'b1;
         end
      end
      for (int i = 0; i < N; i++) begin
         pop[i] = load & sel_valid & (sel == CW'(i));
      end
   end

   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         host_rsp_valid <= 1'b0;
         rr_ptr         <= '0;
      end else if (load) begin
         host_rsp_valid <= sel_valid;
         // next search starts past the winner
         if (sel_valid) begin
            rr_ptr <= sel + 1'b1;
         end
      end
   end

   // held while the host stalls
   always_ff @(posedge pClk) begin
      if (load & sel_valid) begin
         host_rsp <= q_item[sel];
      end
   end

endmodule

// ==== src/memtest_top.sv ====
//**************************************************************************
// memory exerciser top: dispatcher, one engine and memory per channel,
// and the result collector; host sees valid/ready on both sides
//**************************************************************************
`timescale 1ns/1ps
`include "memtest_consts.svh"

module memtest_top (
   input  logic                  pClk,
   input  logic                  rst_n,
   input  memtest_pkg::mem_cmd_t host_cmd,
   input  logic                  host_cmd_valid,
   output logic                  host_cmd_ready,
   output memtest_pkg::mem_rsp_t host_rsp,
   output logic                  host_rsp_valid,
   input  logic                  host_rsp_ready
);
   import memtest_pkg::*;

   localparam int N = `MT_NUM_CHANNELS;

   // dispatcher to channels
   mem_cmd_t              chan_cmd;
   logic                  chan_cmd_push [N];
   logic                  cmd_credit [N];
   // channels to memories
   mem_port_t             mem_req [N];
   logic                  waitrequest [N];
   logic [`MT_DATA_W-1:0] readdata [N];
   logic                  readdatavalid [N];
   // channels to collector
   mem_rsp_t              rsp [N];
   logic                  rsp_push [N];
   logic                  rsp_credit [N];

   mem_cmd_dispatch dispatch_i (
      .pClk           (pClk),
      .rst_n          (rst_n),
      .host_cmd       (host_cmd),
      .host_cmd_valid (host_cmd_valid),
      .cmd_credit     (cmd_credit),
      .host_cmd_ready (host_cmd_ready),
      .chan_cmd       (chan_cmd),
      .chan_cmd_push  (chan_cmd_push)
   );

   for (genvar g = 0; g < N; g++) begin : g_chan
      mem_chan_fsm #(
         .CHAN_ID (g)
      ) chan_i (
         .pClk          (pClk),
         .rst_n         (rst_n),
         .chan_cmd      (chan_cmd),
         .chan_cmd_push (chan_cmd_push[g]),
         .rsp_credit    (rsp_credit[g]),
         .waitrequest   (waitrequest[g]),
         .readdata      (readdata[g]),
         .readdatavalid (readdatavalid[g]),
         .cmd_credit    (cmd_credit[g]),
         .mem_req       (mem_req[g]),
         .rsp           (rsp[g]),
         .rsp_push      (rsp_push[g])
      );

      mem_model mem_i (
         .pClk          (pClk),
         .rst_n         (rst_n),
         .mem_req       (mem_req[g]),
         .waitrequest   (waitrequest[g]),
         .readdata      (readdata[g]),
         .readdatavalid (readdatavalid[g])
      );
   end

   mem_rsp_collect collect_i (
      .pClk           (pClk),
      .rst_n          (rst_n),
      .rsp            (rsp),
      .rsp_push       (rsp_push),
      .host_rsp_ready (host_rsp_ready),
      .rsp_credit     (rsp_credit),
      .host_rsp       (host_rsp),
      .host_rsp_valid (host_rsp_valid)
   );

endmodule

// ==== testbench/memtest_tb.sv ====
//**************************************************************************
// testbench for the memory exerciser: drives host commands on the falling
// edge, predicts each result from a shadow memory and checks every result
//**************************************************************************
`timescale 1ns/1ps
`include "memtest_consts.svh"

module memtest_tb;
   import memtest_pkg::*;

   localparam int N        = `MT_NUM_CHANNELS;
   localparam int CHW      = `MT_CHAN_W;
   localparam int AW       = `MT_MEM_ADDR_W;
   localparam int DW       = `MT_DATA_W;
   localparam int WORDS    = `MT_TEST_WORDS;
   localparam int MAX_OUT  = `MT_CMD_DEPTH + `MT_RSP_DEPTH + 1;
   localparam int CMD_WAIT = 2000;
   localparam int STALL    = 60;
   localparam int DRAIN    = 20000;

   logic     pClk;
   logic     rst_n;
   mem_cmd_t host_cmd;
   logic     host_cmd_valid;
   logic     host_cmd_ready;
   mem_rsp_t host_rsp;
   logic     host_rsp_valid;
   logic     host_rsp_ready;

   // expected results, one queue per channel, plus the shadow memory
   mem_rsp_t          exp_q [N][$];
   logic [DW-1:0]     shadow [N][1 << AW];
   logic [31:0]       rng_state;
   logic [`MT_TAG_W-1:0] next_tag;

   memtest_top dut_i (
      .pClk           (pClk),
      .rst_n          (rst_n),
      .host_cmd       (host_cmd),
      .host_cmd_valid (host_cmd_valid),
      .host_cmd_ready (host_cmd_ready),
      .host_rsp       (host_rsp),
      .host_rsp_valid (host_rsp_valid),
      .host_rsp_ready (host_rsp_ready)
   );

   // 10 ns clock
   always #5 pClk = ~pClk;

   //************************************************************************
   // random numbers and the reference model
   //************************************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // expected result, and the shadow memory follows the command
   function automatic mem_rsp_t ref_result(input mem_cmd_t c);
      mem_rsp_t r;
      int       ch;
      int       a;
      ch          = int'(c.addr[CHW+AW-1:AW]);
      a           = int'(c.addr[AW-1:0]);
      r           = '0;
      r.op        = c.op;
      r.tag       = c.tag;
      r.chan      = c.addr[CHW+AW-1:AW];
      case (c.op)
         MT_OP_WRITE: shadow[ch][a] = c.wdata;
         MT_OP_READ:  r.rdata = shadow[ch][a];
         default: begin
            // window now holds its own addresses, no mismatch expected
            for (int w = 0; w < WORDS; w++) begin
               shadow[ch][w] = DW'(w);
            end
            r.err_count = '0;
         end
      endcase
      return r;
   endfunction

   function automatic mem_cmd_t build_cmd(input mem_op_t op, input int ch, input int a,
                                          input logic [DW-1:0] d);
      mem_cmd_t c;
      c.op    = op;
      c.tag   = next_tag;
      c.addr  = {CHW'(ch), AW'(a)};
      c.wdata = d;
      next_tag = next_tag + 1'b1;
      return c;
   endfunction

   function automatic int pending();
      int total;
      total = 0;
      for (int i = 0; i < N; i++) begin
         total += exp_q[i].size();
      end
      return total;
   endfunction

   //************************************************************************
   // stimulus tasks, entered and left just after a falling edge
   //************************************************************************
   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (8) @(negedge pClk);
      rst_n = 1'b1;
   endtask

   task automatic try_send(input mem_cmd_t c, input int max_wait, output bit ok);
      int waited;
      host_cmd       = c;
      host_cmd_valid = 1'b1;
      ok             = 1'b0;
      waited         = 0;
      while (!ok && waited < max_wait) begin
         @(posedge pClk);
         if (host_cmd_ready) ok = 1'b1;
         else waited++;
      end
      // expectation only for commands the DUT really took
      if (ok) begin
         exp_q[int'(c.addr[CHW+AW-1:AW])].push_back(ref_result(c));
      end
      @(negedge pClk);
      host_cmd_valid = 1'b0;
   endtask

   task automatic send_cmd(input mem_cmd_t c);
      bit ok;
      try_send(c, CMD_WAIT, ok);
      if (!ok) begin
         $display("timeout: host_cmd_ready stayed low for channel %0d", c.addr[CHW+AW-1:AW]);
         $display("STATUS: FAIL");
         $fatal(1);
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (pending() != 0) begin
         @(negedge pClk);
         waited++;
         if (waited > DRAIN) begin
            $display("timeout: %0d results never came back", pending());
            $display("STATUS: FAIL");
            $fatal(1);
         end
      end
   endtask

   // ready of one channel, probed with valid low
   task automatic check_ready(input int ch, input logic want);
      host_cmd.addr = {CHW'(ch), AW'(0)};
      @(posedge pClk);
      assert (host_cmd_ready == want) else begin
         $display("MISMATCH at %0t: host_cmd_ready for channel %0d is %0b, expected %0b",
                  $time, ch, host_cmd_ready, want);
         $display("STATUS: FAIL");
         $fatal(1);
      end
      @(negedge pClk);
   endtask

   task automatic random_burst(input int count);
      logic [31:0] r;
      for (int i = 0; i < count; i++) begin
         r = next_rand();
         send_cmd(build_cmd(r[0] ? MT_OP_WRITE : MT_OP_READ, int'(r[2:1]) % N,
                            int'(r[15:8]) % WORDS, {next_rand(), next_rand()}));
      end
   endtask

   //************************************************************************
   // result checker, samples the handshake at the rising edge
   //************************************************************************
   always @(posedge pClk) begin
      mem_rsp_t got;
      mem_rsp_t exp;
      if (rst_n && host_rsp_valid && host_rsp_ready) begin
         got = host_rsp;
         assert (exp_q[got.chan].size() != 0) else begin
            $display("unexpected result from channel %0d with nothing outstanding", got.chan);
            $display("STATUS: FAIL");
            $fatal(1);
         end
         exp = exp_q[got.chan].pop_front();
         assert (got.op == exp.op && got.tag == exp.tag) else begin
            $display("MISMATCH at %0t: chan %0d op/tag %0d/%0d, expected %0d/%0d",
                     $time, got.chan, got.op, got.tag, exp.op, exp.tag);
            $display("STATUS: FAIL");
            $fatal(1);
         end
         assert (got.op != MT_OP_READ || got.rdata == exp.rdata) else begin
            $display("MISMATCH at %0t: chan %0d tag %0d rdata %h, expected %h",
                     $time, got.chan, got.tag, got.rdata, exp.rdata);
            $display("STATUS: FAIL");
            $fatal(1);
         end
         assert (got.op != MT_OP_ADDR_TEST || got.err_count == exp.err_count) else begin
            $display("MISMATCH at %0t: chan %0d self-test err_count %0d, expected %0d",
                     $time, got.chan, got.err_count, exp.err_count);
            $display("STATUS: FAIL");
            $fatal(1);
         end
      end
   end

   //************************************************************************
   // test sequence
   //************************************************************************
   initial begin
      bit ok;
      int accepted;
      bit blocked;
      pClk           = 1'b0;
      rst_n          = 1'b0;
      host_cmd       = '0;
      host_cmd_valid = 1'b0;
      host_rsp_ready = 1'b1;
      rng_state      = 32'h4d0a1e6d;
      next_tag       = '0;
      apply_reset();

      // out of reset: nothing to return, every channel takes commands
      assert (!host_rsp_valid) else begin
         $display("MISMATCH at %0t: host_rsp_valid is %0b right after reset, expected 0",
                  $time, host_rsp_valid);
         $display("STATUS: FAIL");
         $fatal(1);
      end
      for (int ch = 0; ch < N; ch++) check_ready(ch, 1'b1);

      // write then read the same word, outside the test window
      for (int ch = 0; ch < N; ch++) begin
         send_cmd(build_cmd(MT_OP_WRITE, ch, 200 + ch, {next_rand(), next_rand()}));
         send_cmd(build_cmd(MT_OP_READ, ch, 200 + ch, '0));
      end
      wait_drain();

      // self-test per channel, then read the whole window back
      for (int ch = 0; ch < N; ch++) begin
         send_cmd(build_cmd(MT_OP_ADDR_TEST, ch, 0, '0));
      end
      for (int ch = 0; ch < N; ch++) begin
         for (int w = 0; w < WORDS; w++) send_cmd(build_cmd(MT_OP_READ, ch, w, '0));
      end
      wait_drain();

      // mixed traffic over all channels
      random_burst(300);
      wait_drain();

      // host stalls results, channel 2 backs up until ready drops
      host_rsp_ready = 1'b0;
      accepted       = 0;
      blocked        = 1'b0;
      while (!blocked) begin
         try_send(build_cmd(MT_OP_WRITE, 2, int'(next_rand() % 32'(WORDS)),
                            {next_rand(), next_rand()}), STALL, ok);
         if (ok) accepted++;
         else blocked = 1'b1;
         assert (accepted <= MAX_OUT) else begin
            $display("MISMATCH at %0t: host_cmd_ready high with %0d outstanding, limit %0d",
                     $time, accepted, MAX_OUT);
            $display("STATUS: FAIL");
            $fatal(1);
         end
      end
      // only the stalled channel is closed
      check_ready(2, 1'b0);
      check_ready(3, 1'b1);
      repeat (100) @(negedge pClk);
      host_rsp_ready = 1'b1;
      wait_drain();
      check_ready(2, 1'b1);

      // second reset, memories keep their contents
      apply_reset();
      assert (!host_rsp_valid) else begin
         $display("MISMATCH at %0t: host_rsp_valid is %0b after the second reset, expected 0",
                  $time, host_rsp_valid);
         $display("STATUS: FAIL");
         $fatal(1);
      end
      for (int ch = 0; ch < N; ch++) check_ready(ch, 1'b1);
      random_burst(100);
      wait_drain();

      // late extras would hit the empty-queue check
      repeat (50) @(negedge pClk);
      if (pending() == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         $display("results still outstanding at the end: %0d", pending());
         $display("STATUS: FAIL");
         $fatal(1);
      end
   end

endmodule

// ==== memtest.f ====
+incdir+include
src/memtest_pkg.sv
src/credit_fifo.sv
src/mem_cmd_dispatch.sv
src/mem_chan_fsm.sv
src/mem_model.sv
src/mem_rsp_collect.sv
src/memtest_top.sv
testbench/memtest_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     := memtest_tb
RTL_TOP    := memtest_top
FILELIST   := memtest.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
